// ==== source/cache_pkg.sv ====
package cache_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int STRB_W      = 4;
    localparam int LINE_WORDS  = 4;
    localparam int SETS        = 16;
    localparam int OFFS_W      = 2;
    localparam int IDX_W       = 4;
    localparam int BYTE_OFFS_W = 2;

    // Byte and word offset together address one line
    localparam int LINE_OFFS_W = OFFS_W + BYTE_OFFS_W;
    localparam int TAG_W       = ADDR_W - IDX_W - LINE_OFFS_W;

    // AXI4 burst length field
    localparam int LEN_W       = 8;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } core_req_t;

    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic              burst;
    } cache_bus_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [DATA_W-1:0] rd_data;
        logic              rd_last;
        logic              wr_done;
    } cache_bus_rsp_t;

    typedef struct packed {
        logic              ar_valid;
        logic [ADDR_W-1:0] ar_addr;
        logic [LEN_W-1:0]  ar_len;
        logic              r_ready;
        logic              aw_valid;
        logic [ADDR_W-1:0] aw_addr;
        logic              w_valid;
        logic [DATA_W-1:0] w_data;
        logic [STRB_W-1:0] w_strb;
        logic              w_last;
        logic              b_ready;
    } axi_req_t;

    typedef struct packed {
        logic              ar_ready;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic              r_last;
        logic              aw_ready;
        logic              w_ready;
        logic              b_valid;
    } axi_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE,
        RESPOND
    } cache_state_e;

endpackage

// ==== source/l1_cache_array.sv ====
`timescale 1ns/100ps

module l1_cache_array
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] lookup_addr_i,
    output logic              hit_o,
    output logic [DATA_W-1:0] rdata_o,
    input  logic              refill_we_i,
    input  logic [OFFS_W-1:0] refill_offs_i,
    input  logic [DATA_W-1:0] refill_data_i,
    input  logic              refill_done_i,
    input  logic              store_we_i,
    input  logic [STRB_W-1:0] store_strb_i,
    input  logic [DATA_W-1:0] store_data_i
);

    logic [SETS-1:0]   valid_q;
    logic [TAG_W-1:0]  tag_q  [SETS];
    logic [DATA_W-1:0] data_q [SETS][LINE_WORDS];

    logic [IDX_W-1:0]  idx;
    logic [OFFS_W-1:0] offs;
    logic [TAG_W-1:0]  tag;

    // Address split into tag, set index and word offset
    assign offs = lookup_addr_i[BYTE_OFFS_W +: OFFS_W];
    assign idx  = lookup_addr_i[LINE_OFFS_W +: IDX_W];
    assign tag  = lookup_addr_i[ADDR_W-1 -: TAG_W];

    assign hit_o   = valid_q[idx] && (tag_q[idx] == tag);
    assign rdata_o = data_q[idx][offs];

    // Line stays invalid until its last beat lands
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (refill_done_i) begin
            valid_q[idx] <= 1'b1;
        end else if (refill_we_i) begin
            valid_q[idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we_i) begin
            tag_q[idx] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we_i) begin
            data_q[idx][refill_offs_i] <= refill_data_i;
        end else if (store_we_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (store_strb_i[b]) begin
                    data_q[idx][offs][b*8 +: 8] <= store_data_i[b*8 +: 8];
                end
            end
        end
    end

    // Refill and write-through never overlap, one bus transaction at a time
    a_no_dual_write: assert property (
        @(posedge clk) disable iff (!rst)
        !(refill_we_i && store_we_i)
    ) else $error("refill and store write in the same cycle");

endmodule

// ==== source/l1_cache_ctrl.sv ====
`timescale 1ns/100ps

module l1_cache_ctrl
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              core_valid_i,
    input  core_req_t         core_req_i,
    output logic              core_wait_o,
    output logic [DATA_W-1:0] core_rdata_o,
    input  logic              hit_i,
    input  logic [DATA_W-1:0] array_rdata_i,
    output logic              refill_we_o,
    output logic              refill_done_o,
    output logic              store_we_o,
    output cache_bus_req_t    bus_req_o,
    input  cache_bus_rsp_t    bus_rsp_i,
    output logic              cnt_clear_o,
    input  logic              cnt_last_i
);

    cache_state_e state_q;
    cache_state_e state_d;
    core_req_t    req_q;
    logic         bus_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request held here for the bus payload
    always_ff @(posedge clk) begin
        if (state_q == IDLE && core_valid_i) begin
            req_q <= core_req_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (core_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req_q.write) begin
                    state_d = WRITE;
                end else if (hit_i) begin
                    state_d = RESPOND;
                end else begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                if (bus_rsp_i.rd_valid && cnt_last_i) begin
                    state_d = RESPOND;
                end
            end
            WRITE: begin
                if (bus_rsp_i.wr_done) begin
                    state_d = RESPOND;
                end
            end
            RESPOND: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // Wait follows the request level, released only in RESPOND
    assign core_wait_o  = core_valid_i && (state_q != RESPOND);
    assign core_rdata_o = array_rdata_i;

    assign cnt_clear_o   = (state_q == LOOKUP) && (state_d == REFILL);
    assign refill_we_o   = (state_q == REFILL) && bus_rsp_i.rd_valid;
    assign refill_done_o = refill_we_o && cnt_last_i;

    // No write allocate, only a hit line gets the new bytes
    assign store_we_o = (state_q == WRITE) && bus_rsp_i.wr_done && hit_i;

    always_comb begin
        bus_req_o.req   = (state_q == REFILL) || (state_q == WRITE);
        bus_req_o.burst = (state_q == REFILL);
        bus_req_o.write = (state_q == WRITE);
        bus_req_o.wdata = req_q.wdata;
        bus_req_o.strb  = req_q.strb;
        if (state_q == REFILL) begin
            bus_req_o.addr = {req_q.addr[ADDR_W-1:LINE_OFFS_W], {LINE_OFFS_W{1'b0}}};
        end else begin
            bus_req_o.addr = req_q.addr;
        end
    end

    assign bus_done = (bus_rsp_i.rd_valid && bus_rsp_i.rd_last) || bus_rsp_i.wr_done;

    // Request strobe only drops after the master reports completion
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst)
        $fell(bus_req_o.req) |-> $past(bus_done)
    ) else $error("bus request dropped before completion");

endmodule

// ==== source/refill_counter.sv ====
`timescale 1ns/100ps

module refill_counter
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              clear_i,
    input  logic              beat_i,
    input  logic              beat_last_i,
    output logic [OFFS_W-1:0] offs_o,
    output logic              last_o
);

    logic [OFFS_W-1:0] cnt_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (beat_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign offs_o = cnt_q;
    assign last_o = (cnt_q == OFFS_W'(LINE_WORDS - 1));

    // Bus last must land on the fourth beat, not earlier or later
    a_last_match: assert property (
        @(posedge clk) disable iff (!rst)
        beat_i |-> (beat_last_i == last_o)
    ) else $error("r_last %0b while counter last %0b", beat_last_i, last_o);

    a_no_wrap: assert property (
        @(posedge clk) disable iff (!rst)
        (beat_i && last_o) |=> (!beat_i until clear_i)
    ) else $error("refill beat after last without clear");

endmodule

// ==== source/axi_master.sv ====
`timescale 1ns/100ps

module axi_master
    import cache_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  cache_bus_req_t bus_req_i,
    output cache_bus_rsp_t bus_rsp_o,
    output axi_req_t       axi_req_o,
    input  axi_rsp_t       axi_rsp_i
);

    logic              busy_q;
    logic              addr_done_q;
    logic              data_done_q;
    logic              write_q;
    logic              burst_q;
    logic [ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0] wdata_q;
    logic [STRB_W-1:0] strb_q;

    logic start;
    logic ar_hs;
    logic r_hs;
    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign start = bus_req_i.req && !busy_q;

    // Channel valids derive from the phase flags
    assign axi_req_o.ar_valid = busy_q && !write_q && !addr_done_q;
    assign axi_req_o.ar_addr  = addr_q;
    assign axi_req_o.ar_len   = burst_q ? LEN_W'(LINE_WORDS - 1) : '0;
    assign axi_req_o.r_ready  = busy_q && !write_q && addr_done_q;
    assign axi_req_o.aw_valid = busy_q && write_q && !addr_done_q;
    assign axi_req_o.aw_addr  = addr_q;
    assign axi_req_o.w_valid  = busy_q && write_q && !data_done_q;
    assign axi_req_o.w_data   = wdata_q;
    assign axi_req_o.w_strb   = strb_q;
    assign axi_req_o.w_last   = 1'b1;
    assign axi_req_o.b_ready  = busy_q && write_q && addr_done_q && data_done_q;

    assign ar_hs = axi_req_o.ar_valid && axi_rsp_i.ar_ready;
    assign r_hs  = axi_req_o.r_ready && axi_rsp_i.r_valid;
    assign aw_hs = axi_req_o.aw_valid && axi_rsp_i.aw_ready;
    assign w_hs  = axi_req_o.w_valid && axi_rsp_i.w_ready;
    assign b_hs  = axi_req_o.b_ready && axi_rsp_i.b_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy_q      <= 1'b0;
            addr_done_q <= 1'b0;
            data_done_q <= 1'b0;
        end else if (start) begin
            busy_q <= 1'b1;
        end else if ((r_hs && axi_rsp_i.r_last) || b_hs) begin
            busy_q      <= 1'b0;
            addr_done_q <= 1'b0;
            data_done_q <= 1'b0;
        end else begin
            if (ar_hs || aw_hs) begin
                addr_done_q <= 1'b1;
            end
            if (w_hs) begin
                data_done_q <= 1'b1;
            end
        end
    end

    // Payload latched once so AXI fields stay put while valid waits
    always_ff @(posedge clk) begin
        if (start) begin
            write_q <= bus_req_i.write;
            burst_q <= bus_req_i.burst;
            addr_q  <= bus_req_i.addr;
            wdata_q <= bus_req_i.wdata;
            strb_q  <= bus_req_i.strb;
        end
    end

    assign bus_rsp_o.rd_valid = r_hs;
    assign bus_rsp_o.rd_data  = axi_rsp_i.r_data;
    assign bus_rsp_o.rd_last  = axi_rsp_i.r_last;
    assign bus_rsp_o.wr_done  = b_hs;

    // AR carries the address the controller still holds
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst)
        axi_req_o.ar_valid |-> (bus_req_i.req && axi_req_o.ar_addr == bus_req_i.addr)
    ) else $error("ar_addr left the held bus request while ar_valid waited");

endmodule

// ==== source/cpu_mem_wrapper.sv ====
`timescale 1ns/100ps

module cpu_mem_wrapper
    import cache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              core_valid_i,
    input  core_req_t         core_req_i,
    output logic              core_wait_o,
    output logic [DATA_W-1:0] core_rdata_o,
    output axi_req_t          axi_req_o,
    input  axi_rsp_t          axi_rsp_i
);

    cache_bus_req_t    bus_req;
    cache_bus_rsp_t    bus_rsp;
    logic              hit;
    logic [DATA_W-1:0] array_rdata;
    logic              refill_we;
    logic              refill_done;
    logic              store_we;
    logic              cnt_clear;
    logic              cnt_last;
    logic [OFFS_W-1:0] cnt_offs;

    l1_cache_ctrl u_ctrl (
        .clk           (clk         ),
        .rst           (rst         ),
        .core_valid_i  (core_valid_i),
        .core_req_i    (core_req_i  ),
        .core_wait_o   (core_wait_o ),
        .core_rdata_o  (core_rdata_o),
        .hit_i         (hit         ),
        .array_rdata_i (array_rdata ),
        .refill_we_o   (refill_we   ),
        .refill_done_o (refill_done ),
        .store_we_o    (store_we    ),
        .bus_req_o     (bus_req     ),
        .bus_rsp_i     (bus_rsp     ),
        .cnt_clear_o   (cnt_clear   ),
        .cnt_last_i    (cnt_last    )
    );

    // Core holds its address for the whole access, so lookup uses it directly
    l1_cache_array u_array (
        .clk           (clk            ),
        .rst           (rst            ),
        .lookup_addr_i (core_req_i.addr),
        .hit_o         (hit            ),
        .rdata_o       (array_rdata    ),
        .refill_we_i   (refill_we      ),
        .refill_offs_i (cnt_offs       ),
        .refill_data_i (bus_rsp.rd_data),
        .refill_done_i (refill_done    ),
        .store_we_i    (store_we       ),
        .store_strb_i  (bus_req.strb   ),
        .store_data_i  (bus_req.wdata  )
    );

    refill_counter u_cnt (
        .clk         (clk             ),
        .rst         (rst             ),
        .clear_i     (cnt_clear       ),
        .beat_i      (bus_rsp.rd_valid),
        .beat_last_i (bus_rsp.rd_last ),
        .offs_o      (cnt_offs        ),
        .last_o      (cnt_last        )
    );

    axi_master u_master (
        .clk       (clk      ),
        .rst       (rst      ),
        .bus_req_i (bus_req  ),
        .bus_rsp_o (bus_rsp  ),
        .axi_req_o (axi_req_o),
        .axi_rsp_i (axi_rsp_i)
    );

endmodule

// ==== sim/axi_mem_model.sv ====
`timescale 1ns/100ps

module axi_mem_model
    import cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  axi_req_t axi_req_i,
    output axi_rsp_t axi_rsp_o
);

    logic [DATA_W-1:0] mem [256];
    int unsigned       delays [1024];
    int unsigned       fill = 0;
    int unsigned       pos = 0;

    task automatic add_delay(input int unsigned d);
        delays[fill % 1024] = d;
        fill = fill + 1;
    endtask

    // Delay pool is used as a ring, entered and left at 1 ns after the edge
    task automatic stall();
        int unsigned d;
        d = (fill == 0) ? 0 : delays[pos % ((fill > 1024) ? 1024 : fill)];
        pos = pos + 1;
        repeat (d) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic read_burst();
        logic [7:0] word;
        logic [7:0] len;
        word = axi_req_i.ar_addr[9:2];
        len  = axi_req_i.ar_len;
        #1;
        stall();
        axi_rsp_o.ar_ready = 1'b1;
        @(posedge clk);
        #1;
        axi_rsp_o.ar_ready = 1'b0;
        for (int b = 0; b <= len; b++) begin
            stall();
            axi_rsp_o.r_valid = 1'b1;
            axi_rsp_o.r_data  = mem[8'(word + b)];
            axi_rsp_o.r_last  = (b == len);
            do @(posedge clk); while (!axi_req_i.r_ready);
            #1;
            axi_rsp_o.r_valid = 1'b0;
        end
    endtask

    // AW first, then W, then B
    task automatic write_single();
        logic [7:0] word;
        word = axi_req_i.aw_addr[9:2];
        #1;
        stall();
        axi_rsp_o.aw_ready = 1'b1;
        @(posedge clk);
        #1;
        axi_rsp_o.aw_ready = 1'b0;
        stall();
        axi_rsp_o.w_ready = 1'b1;
        @(posedge clk);
        for (int b = 0; b < STRB_W; b++) begin
            if (axi_req_i.w_strb[b]) begin
                mem[word][b*8 +: 8] = axi_req_i.w_data[b*8 +: 8];
            end
        end
        #1;
        axi_rsp_o.w_ready = 1'b0;
        stall();
        axi_rsp_o.b_valid = 1'b1;
        do @(posedge clk); while (!axi_req_i.b_ready);
        #1;
        axi_rsp_o.b_valid = 1'b0;
    endtask

    initial begin
        axi_rsp_o = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) ^ 32'hA5A5_0000;
        end
        forever begin
            @(posedge clk);
            if (rst && axi_req_i.ar_valid) begin
                read_burst();
            end else if (rst && axi_req_i.aw_valid) begin
                write_single();
            end
        end
    end

endmodule

// ==== sim/tb_cpu_mem_wrapper.sv ====
`timescale 1ns/100ps

module tb_cpu_mem_wrapper
    import cache_pkg::*;
();

    localparam int ACCESSES   = 120;
    localparam int MAX_CYCLES = 4000;

    logic              clk;
    logic              rst;
    logic              core_valid;
    core_req_t         core_req;
    logic              core_wait;
    logic [DATA_W-1:0] core_rdata;
    axi_req_t          axi_req;
    axi_rsp_t          axi_rsp;

    logic [31:0]       rng;
    logic [DATA_W-1:0] shadow [256];
    logic [SETS-1:0]   line_valid;
    logic [23:0]       line_tag [SETS];
    logic              exp_hit;
    logic [DATA_W-1:0] exp_rdata;
    logic [19:0]       exp_cnt;
    logic [3:0]        ar_cnt;
    logic [3:0]        r_cnt;
    logic [3:0]        aw_cnt;
    logic [3:0]        w_cnt;
    logic [3:0]        b_cnt;
    logic              done;
    logic [ADDR_W-1:0] line_addr;
    int                cycles = 0;

    cpu_mem_wrapper u_dut (
        .clk          (clk       ),
        .rst          (rst       ),
        .core_valid_i (core_valid),
        .core_req_i   (core_req  ),
        .core_wait_o  (core_wait ),
        .core_rdata_o (core_rdata),
        .axi_req_o    (axi_req   ),
        .axi_rsp_i    (axi_rsp   )
    );

    axi_mem_model u_mem (
        .clk       (clk    ),
        .rst       (rst    ),
        .axi_req_i (axi_req),
        .axi_rsp_o (axi_rsp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    assign done      = core_valid && !core_wait;
    assign line_addr = {core_req.addr[ADDR_W-1:4], 4'b0000};

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        fail_run($sformatf("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp));
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            fail_run("Timeout: the accesses did not finish within 4000 cycles");
        end
    end

    // Handshakes seen during the current access
    always @(posedge clk) begin
        if (!core_valid) begin
            ar_cnt <= '0;
            r_cnt  <= '0;
            aw_cnt <= '0;
            w_cnt  <= '0;
            b_cnt  <= '0;
        end else begin
            ar_cnt <= ar_cnt + 4'(axi_req.ar_valid && axi_rsp.ar_ready);
            r_cnt  <= r_cnt + 4'(axi_req.r_ready && axi_rsp.r_valid);
            aw_cnt <= aw_cnt + 4'(axi_req.aw_valid && axi_rsp.aw_ready);
            w_cnt  <= w_cnt + 4'(axi_req.w_valid && axi_rsp.w_ready);
            b_cnt  <= b_cnt + 4'(axi_req.b_ready && axi_rsp.b_valid);
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        (cycles >= 2 && (!rst || $past(!rst)))
            |-> !(core_wait || axi_req.ar_valid || axi_req.aw_valid || axi_req.w_valid
                  || axi_req.r_ready || axi_req.b_ready))
        else fail_run("core_wait_o or an AXI valid or ready was high in or right after reset");

    a_rdata: assert property (@(posedge clk) disable iff (!rst)
        (done && !core_req.write) |-> core_rdata == exp_rdata)
        else value_error("core_rdata_o", $sampled(core_rdata), $sampled(exp_rdata));

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst)
        ($rose(core_valid) && exp_hit)
            |-> (core_wait && !axi_req.ar_valid) [*2] ##1 (!core_wait && !axi_req.ar_valid))
        else fail_run("Read hit did not finish two cycles after core_valid_i rose, or used AR");

    a_counts: assert property (@(posedge clk) disable iff (!rst)
        done |-> {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} == exp_cnt)
        else value_error("ar/r/aw/w/b handshake counts",
                         $sampled({ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt}), $sampled(exp_cnt));

    a_ar: assert property (@(posedge clk) disable iff (!rst)
        axi_req.ar_valid |-> {axi_req.ar_len, axi_req.ar_addr} == {8'd3, line_addr})
        else value_error("ar_len,ar_addr", $sampled({axi_req.ar_len, axi_req.ar_addr}),
                         $sampled({8'd3, line_addr}));

    a_r_last: assert property (@(posedge clk) disable iff (!rst)
        (axi_req.r_ready && axi_rsp.r_valid) |-> axi_rsp.r_last == (r_cnt == 4'd3))
        else value_error("r_last", $sampled(axi_rsp.r_last), $sampled(r_cnt == 4'd3));

    a_aw: assert property (@(posedge clk) disable iff (!rst)
        axi_req.aw_valid |-> axi_req.aw_addr == core_req.addr)
        else value_error("aw_addr", $sampled(axi_req.aw_addr), $sampled(core_req.addr));

    a_w: assert property (@(posedge clk) disable iff (!rst)
        axi_req.w_valid |-> {axi_req.w_last, axi_req.w_strb, axi_req.w_data}
                            == {1'b1, core_req.strb, core_req.wdata})
        else value_error("w_last,w_strb,w_data",
                         $sampled({axi_req.w_last, axi_req.w_strb, axi_req.w_data}),
                         $sampled({1'b1, core_req.strb, core_req.wdata}));

    a_write_wait: assert property (@(posedge clk) disable iff (!rst)
        (core_valid && core_req.write && b_cnt == 4'd0) |-> core_wait)
        else fail_run("core_wait_o dropped before the B handshake of a write");

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst)
        (axi_req.ar_valid && !axi_rsp.ar_ready)
            |=> (axi_req.ar_valid && $stable({axi_req.ar_addr, axi_req.ar_len})))
        else fail_run("AR payload changed or ar_valid dropped while waiting for ar_ready");

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst)
        (axi_req.aw_valid && !axi_rsp.aw_ready)
            |=> (axi_req.aw_valid && $stable(axi_req.aw_addr)))
        else fail_run("AW payload changed or aw_valid dropped while waiting for aw_ready");

    a_w_stable: assert property (@(posedge clk) disable iff (!rst)
        (axi_req.w_valid && !axi_rsp.w_ready)
            |=> (axi_req.w_valid
                 && $stable({axi_req.w_data, axi_req.w_strb, axi_req.w_last})))
        else fail_run("W payload changed or w_valid dropped while waiting for w_ready");

    task automatic run_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
        logic [7:0] word;
        logic [3:0] set;
        word = addr[9:2];
        set  = addr[7:4];
        @(posedge clk);
        #1;
        exp_hit   = !wr && line_valid[set] && (line_tag[set] == addr[ADDR_W-1:8]);
        exp_rdata = shadow[word];
        if (wr) begin
            exp_cnt = {8'd0, 4'd1, 4'd1, 4'd1};
        end else if (exp_hit) begin
            exp_cnt = '0;
        end else begin
            exp_cnt = {4'd1, 4'd4, 12'd0};
        end
        core_req   = '{addr: addr, write: wr, wdata: data, strb: strb};
        core_valid = 1'b1;
        do @(negedge clk); while (core_wait);
        @(posedge clk);
        #1;
        core_valid = 1'b0;
        if (wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    shadow[word][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end else begin
            line_valid[set] = 1'b1;
            line_tag[set]   = addr[ADDR_W-1:8];
        end
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              wr;
        rng        = 32'h85ba;
        rst        = 1'b0;
        core_valid = 1'b0;
        core_req   = '0;
        exp_hit    = 1'b0;
        exp_rdata  = '0;
        exp_cnt    = '0;
        line_valid = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'(i) ^ 32'hA5A5_0000;
        end
        for (int i = 0; i < 1024; i++) begin
            rng = xorshift(rng);
            u_mem.add_delay(rng[1:0]);
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        // 512 bytes over a 256 byte cache gives a mix of hits, misses and evictions
        for (int n = 0; n < ACCESSES; n++) begin
            rng  = xorshift(rng);
            addr = {23'd0, rng[8:2], 2'b00};
            wr   = (rng[15:14] == 2'b00);
            strb = (rng[19:16] == 4'h0) ? 4'hF : rng[19:16];
            rng  = xorshift(rng);
            data = rng;
            run_access(wr, addr, data, strb);
        end
        // Partial write to a cached line, then to a line of the same set that is not cached
        run_access(1'b0, 32'h0000_0040, '0, 4'hF);
        run_access(1'b1, 32'h0000_0044, 32'h1122_3344, 4'b0101);
        run_access(1'b0, 32'h0000_0044, '0, 4'hF);
        run_access(1'b1, 32'h0000_0148, 32'h5566_7788, 4'b1010);
        run_access(1'b0, 32'h0000_0148, '0, 4'hF);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sim.f ====
source/cache_pkg.sv
source/l1_cache_array.sv
source/l1_cache_ctrl.sv
source/refill_counter.sv
source/axi_master.sv
source/cpu_mem_wrapper.sv
sim/axi_mem_model.sv
sim/tb_cpu_mem_wrapper.sv

// ==== Bender.yml ====
package:
  name: cpu_mem_wrapper

sources:
  - source/cache_pkg.sv
  - source/l1_cache_array.sv
  - source/l1_cache_ctrl.sv
  - source/refill_counter.sv
  - source/axi_master.sv
  - source/cpu_mem_wrapper.sv
  - target: simulation
    files:
      - sim/axi_mem_model.sv
      - sim/tb_cpu_mem_wrapper.sv
